//--- hw/idiv_pkg.sv
// shared constants of the iterative integer divider
// widths, step count, fixed latency, operand mux codes and FSM step codes
`default_nettype none

package idiv_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  // operand and result width
  localparam int DATA_WIDTH = 32;
  // operand registers and adder carry one extra sign bit
  localparam int OP_WIDTH = DATA_WIDTH + 1;

  // one iterate step per bit of the extended dividend
  localparam int ITER_COUNT = DATA_WIDTH + 1;
  localparam int ITER_CNT_WIDTH = $clog2(ITER_COUNT);
  // cycles from the accepting edge to the rise of v_o
  localparam int DIV_LATENCY = 40;

  // ----------------------------------------
  // operand mux selects, one-hot
  // ----------------------------------------
  localparam int SEL_WIDTH = 3;
  // B register sources
  localparam logic [SEL_WIDTH-1:0] OPB_SEL_SHIFT  = 3'b001;
  localparam logic [SEL_WIDTH-1:0] OPB_SEL_SUM    = 3'b010;
  localparam logic [SEL_WIDTH-1:0] OPB_SEL_KEEP_C = 3'b100;
  // C register sources
  localparam logic [SEL_WIDTH-1:0] OPC_SEL_SHIFT_Q  = 3'b001;
  localparam logic [SEL_WIDTH-1:0] OPC_SEL_SUM      = 3'b010;
  localparam logic [SEL_WIDTH-1:0] OPC_SEL_DIVIDEND = 3'b100;

  // ----------------------------------------
  // controller step codes
  // ----------------------------------------
  localparam int STEP_WIDTH = 4;
  localparam logic [STEP_WIDTH-1:0] STEP_IDLE         = 4'd0;
  localparam logic [STEP_WIDTH-1:0] STEP_LATCH        = 4'd1;
  localparam logic [STEP_WIDTH-1:0] STEP_NEG_DIVISOR  = 4'd2;
  localparam logic [STEP_WIDTH-1:0] STEP_NEG_DIVIDEND = 4'd3;
  localparam logic [STEP_WIDTH-1:0] STEP_SHIFT        = 4'd4;
  localparam logic [STEP_WIDTH-1:0] STEP_ITERATE      = 4'd5;
  localparam logic [STEP_WIDTH-1:0] STEP_REPAIR       = 4'd6;
  localparam logic [STEP_WIDTH-1:0] STEP_NEG_REM      = 4'd7;
  localparam logic [STEP_WIDTH-1:0] STEP_NEG_QUOT     = 4'd8;
  localparam logic [STEP_WIDTH-1:0] STEP_DONE         = 4'd9;

endpackage

`default_nettype wire

//--- hw/idiv_ctrl_if.sv
// divider control bundle
// operand commands go from the step controller to the datapath,
// sign and zero status comes back
`timescale 1ns/1ps
`default_nettype none

interface idiv_ctrl_if;

  // ----------------------------------------
  // commands from the controller
  // ----------------------------------------
  // A source, 1 takes the signed divisor, 0 takes the sum
  logic                               opa_sel;
  logic                               opa_ld;
  logic                               opb_ld;
  logic                               opc_ld;
  // adder input conditioning
  logic                               opa_inv;
  logic                               opb_inv;
  logic                               opa_clr;
  logic                               opb_clr;
  // one-hot selects of the B and C muxes
  logic [idiv_pkg::SEL_WIDTH-1:0]     opb_sel;
  logic [idiv_pkg::SEL_WIDTH-1:0]     opc_sel;
  // capture of the request operands
  logic                               latch_inputs;
  logic                               adder_cin;

  // ----------------------------------------
  // status from the datapath
  // ----------------------------------------
  logic                               signed_div;
  logic                               sum_neg;
  logic                               opa_neg;
  logic                               opc_neg;
  logic                               divisor_zero;

  // step controller side
  modport ctrl (
    output opa_sel, opa_ld, opb_ld, opc_ld,
    output opa_inv, opb_inv, opa_clr, opb_clr,
    output opb_sel, opc_sel, latch_inputs, adder_cin,
    input  signed_div, sum_neg, opa_neg, opc_neg, divisor_zero
  );

  // datapath side
  modport dp (
    input  opa_sel, opa_ld, opb_ld, opc_ld,
    input  opa_inv, opb_inv, opa_clr, opb_clr,
    input  opb_sel, opc_sel, latch_inputs, adder_cin,
    output signed_div, sum_neg, opa_neg, opc_neg, divisor_zero
  );

endinterface

`default_nettype wire

//--- hw/idiv_datapath.sv
// divider datapath
// input latches, operand registers A, B and C with their muxes,
// invert and clear stages and one 33-bit adder with carry-in
// A ends as the remainder, C ends as the quotient
`timescale 1ns/1ps
`default_nettype none

module idiv_datapath (
  input  logic                            clk_i,
  input  logic [idiv_pkg::DATA_WIDTH-1:0] dividend_i,
  input  logic [idiv_pkg::DATA_WIDTH-1:0] divisor_i,
  input  logic                            signed_div_i,
  output logic [idiv_pkg::DATA_WIDTH-1:0] quotient_o,
  output logic [idiv_pkg::DATA_WIDTH-1:0] remainder_o,
  idiv_ctrl_if.dp                         ctrl
);

  // invert then clear, in front of each adder input
  function automatic logic [idiv_pkg::OP_WIDTH-1:0] condition_op(
    input logic [idiv_pkg::OP_WIDTH-1:0] op,
    input logic                          inv,
    input logic                          clr
  );
    logic [idiv_pkg::OP_WIDTH-1:0] flipped;
    flipped = op ^ {idiv_pkg::OP_WIDTH{inv}};
    return flipped & {idiv_pkg::OP_WIDTH{~clr}};
  endfunction

  // ----------------------------------------
  // request latches
  // ----------------------------------------
  logic                            signed_div_r;
  logic [idiv_pkg::DATA_WIDTH-1:0] dividend_r;
  logic [idiv_pkg::DATA_WIDTH-1:0] divisor_r;

  always_ff @(posedge clk_i) begin
    if (ctrl.latch_inputs) begin
      signed_div_r <= signed_div_i;
      dividend_r   <= dividend_i;
      divisor_r    <= divisor_i;
    end
  end

  // extension bits, only set for a signed request
  logic divisor_msb;
  logic dividend_msb;
  assign divisor_msb  = signed_div_r & divisor_r[idiv_pkg::DATA_WIDTH-1];
  assign dividend_msb = signed_div_r & dividend_r[idiv_pkg::DATA_WIDTH-1];

  // ----------------------------------------
  // operand registers and muxes
  // ----------------------------------------
  logic [idiv_pkg::OP_WIDTH-1:0] opa_r;
  logic [idiv_pkg::OP_WIDTH-1:0] opb_r;
  logic [idiv_pkg::OP_WIDTH-1:0] opc_r;
  logic [idiv_pkg::OP_WIDTH-1:0] opa_mux;
  logic [idiv_pkg::OP_WIDTH-1:0] opb_mux;
  logic [idiv_pkg::OP_WIDTH-1:0] opc_mux;
  logic [idiv_pkg::OP_WIDTH-1:0] sum;

  // A holds the divisor, later the remainder
  assign opa_mux = ctrl.opa_sel ? {divisor_msb, divisor_r} : sum;

  // B is the partial remainder
  always_comb begin
    case (ctrl.opb_sel)
      idiv_pkg::OPB_SEL_KEEP_C: opb_mux = opc_r;
      idiv_pkg::OPB_SEL_SUM:    opb_mux = sum;
      // doubled sum with the next dividend bit from the top of C
      default: opb_mux = {sum[idiv_pkg::OP_WIDTH-2:0], opc_r[idiv_pkg::OP_WIDTH-1]};
    endcase
  end

  // C shifts the dividend out at the top and the quotient in at the bottom
  always_comb begin
    case (ctrl.opc_sel)
      idiv_pkg::OPC_SEL_DIVIDEND: opc_mux = {dividend_msb, dividend_r};
      idiv_pkg::OPC_SEL_SUM:      opc_mux = sum;
      // quotient bit is set when the new partial remainder is not negative
      default: opc_mux = {opc_r[idiv_pkg::OP_WIDTH-2:0], ~sum[idiv_pkg::OP_WIDTH-1]};
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (ctrl.opa_ld) begin
      opa_r <= opa_mux;
    end
    if (ctrl.opb_ld) begin
      opb_r <= opb_mux;
    end
    if (ctrl.opc_ld) begin
      opc_r <= opc_mux;
    end
  end

  // ----------------------------------------
  // adder
  // ----------------------------------------
  logic [idiv_pkg::OP_WIDTH-1:0] add_a;
  logic [idiv_pkg::OP_WIDTH-1:0] add_b;

  assign add_a = condition_op(opa_r, ctrl.opa_inv, ctrl.opa_clr);
  assign add_b = condition_op(opb_r, ctrl.opb_inv, ctrl.opb_clr);

  // carry out drops, the sum wraps at 33 bits
  assign sum = add_a + add_b + {{(idiv_pkg::OP_WIDTH-1){1'b0}}, ctrl.adder_cin};

  // status back to the controller
  assign ctrl.signed_div   = signed_div_r;
  assign ctrl.sum_neg      = sum[idiv_pkg::OP_WIDTH-1];
  assign ctrl.opa_neg      = opa_r[idiv_pkg::OP_WIDTH-1];
  assign ctrl.opc_neg      = opc_r[idiv_pkg::OP_WIDTH-1];
  assign ctrl.divisor_zero = (divisor_r == '0);

  // results straight from the operand registers
  assign quotient_o  = opc_r[idiv_pkg::DATA_WIDTH-1:0];
  assign remainder_o = opa_r[idiv_pkg::DATA_WIDTH-1:0];

endmodule

`default_nettype wire

//--- hw/idiv_controller.sv
// divider step controller
// walks latch, negate, shift, iterate, repair and negate-back one step per
// cycle and drives every operand command of the datapath
// fixed latency, skipped work still spends its cycle
`timescale 1ns/1ps
`default_nettype none

module idiv_controller (
  input  logic    clk_i,
  input  logic    arst_n_i,
  input  logic    v_i,
  output logic    ready_o,
  output logic    v_o,
  input  logic    yumi_i,
  idiv_ctrl_if.ctrl ctrl
);

  logic [idiv_pkg::STEP_WIDTH-1:0]     step_r;
  logic [idiv_pkg::STEP_WIDTH-1:0]     step_nxt;
  logic [idiv_pkg::ITER_CNT_WIDTH-1:0] iter_cnt_r;
  logic                                iter_last;
  // sign of the previous cycle's sum
  logic                                sum_neg_r;
  // result signs, taken once the operands sit in A and C
  logic                                q_neg_r;
  logic                                r_neg_r;

  assign iter_last = (iter_cnt_r == idiv_pkg::ITER_CNT_WIDTH'(idiv_pkg::ITER_COUNT - 1));

  // handshake
  assign ready_o = (step_r == idiv_pkg::STEP_IDLE);
  assign v_o     = (step_r == idiv_pkg::STEP_DONE);

  // ----------------------------------------
  // state and flags
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      step_r     <= idiv_pkg::STEP_IDLE;
      iter_cnt_r <= '0;
      sum_neg_r  <= 1'b0;
      q_neg_r    <= 1'b0;
      r_neg_r    <= 1'b0;
    end else begin
      step_r    <= step_nxt;
      sum_neg_r <= ctrl.sum_neg;
      // quotient sign from both operands, remainder follows the dividend
      if (step_r == idiv_pkg::STEP_NEG_DIVISOR) begin
        q_neg_r <= ctrl.signed_div & (ctrl.opa_neg ^ ctrl.opc_neg);
        r_neg_r <= ctrl.signed_div & ctrl.opc_neg;
      end
      if (step_r == idiv_pkg::STEP_SHIFT) begin
        iter_cnt_r <= '0;
      end else if (step_r == idiv_pkg::STEP_ITERATE) begin
        iter_cnt_r <= iter_cnt_r + idiv_pkg::ITER_CNT_WIDTH'(1);
      end
    end
  end

  // ----------------------------------------
  // commands and next step
  // ----------------------------------------
  always_comb begin
    // idle defaults, nothing loads
    ctrl.opa_sel      = 1'b0;
    ctrl.opa_ld       = 1'b0;
    ctrl.opb_ld       = 1'b0;
    ctrl.opc_ld       = 1'b0;
    ctrl.opa_inv      = 1'b0;
    ctrl.opb_inv      = 1'b0;
    ctrl.opa_clr      = 1'b0;
    ctrl.opb_clr      = 1'b0;
    ctrl.opb_sel      = idiv_pkg::OPB_SEL_SHIFT;
    ctrl.opc_sel      = idiv_pkg::OPC_SEL_SHIFT_Q;
    ctrl.latch_inputs = 1'b0;
    ctrl.adder_cin    = 1'b0;
    step_nxt          = step_r;

    case (step_r)
      idiv_pkg::STEP_IDLE: begin
        // the accepting edge captures the request
        if (v_i) begin
          ctrl.latch_inputs = 1'b1;
          step_nxt          = idiv_pkg::STEP_LATCH;
        end
      end

      idiv_pkg::STEP_LATCH: begin
        // sign-extended divisor into A, dividend into C
        ctrl.opa_sel = 1'b1;
        ctrl.opa_ld  = 1'b1;
        ctrl.opc_sel = idiv_pkg::OPC_SEL_DIVIDEND;
        ctrl.opc_ld  = 1'b1;
        step_nxt     = idiv_pkg::STEP_NEG_DIVISOR;
      end

      idiv_pkg::STEP_NEG_DIVISOR: begin
        // A <= ~A + 1 for a negative divisor
        ctrl.opa_inv   = 1'b1;
        ctrl.opb_clr   = 1'b1;
        ctrl.adder_cin = 1'b1;
        ctrl.opa_ld    = ctrl.opa_neg;
        // stage the dividend in B for the next negation
        ctrl.opb_sel   = idiv_pkg::OPB_SEL_KEEP_C;
        ctrl.opb_ld    = 1'b1;
        step_nxt       = idiv_pkg::STEP_NEG_DIVIDEND;
      end

      idiv_pkg::STEP_NEG_DIVIDEND: begin
        // C <= ~B + 1 for a negative dividend
        ctrl.opa_clr   = 1'b1;
        ctrl.opb_inv   = 1'b1;
        ctrl.adder_cin = 1'b1;
        ctrl.opc_sel   = idiv_pkg::OPC_SEL_SUM;
        ctrl.opc_ld    = ctrl.opc_neg;
        step_nxt       = idiv_pkg::STEP_SHIFT;
      end

      idiv_pkg::STEP_SHIFT: begin
        // zero sum, so B takes only the top bit of C
        // and the first iterate subtracts
        ctrl.opa_clr = 1'b1;
        ctrl.opb_clr = 1'b1;
        ctrl.opb_ld  = 1'b1;
        ctrl.opc_ld  = 1'b1;
        step_nxt     = idiv_pkg::STEP_ITERATE;
      end

      idiv_pkg::STEP_ITERATE: begin
        // non-restoring step
        // subtract after a non-negative sum, add after a negative one
        ctrl.opa_inv   = ~sum_neg_r;
        ctrl.adder_cin = ~sum_neg_r;
        ctrl.opb_ld    = 1'b1;
        ctrl.opc_ld    = 1'b1;
        // last step keeps the unshifted partial remainder
        if (iter_last) begin
          ctrl.opb_sel = idiv_pkg::OPB_SEL_SUM;
          step_nxt     = idiv_pkg::STEP_REPAIR;
        end
      end

      idiv_pkg::STEP_REPAIR: begin
        // B <= B + A when the final partial remainder went negative
        ctrl.opb_sel = idiv_pkg::OPB_SEL_SUM;
        ctrl.opb_ld  = sum_neg_r;
        step_nxt     = idiv_pkg::STEP_NEG_REM;
      end

      idiv_pkg::STEP_NEG_REM: begin
        // remainder moves into A, negated only for a negative dividend
        ctrl.opa_clr   = 1'b1;
        ctrl.opb_inv   = r_neg_r;
        ctrl.adder_cin = r_neg_r;
        ctrl.opa_ld    = 1'b1;
        // quotient goes to B for its own negation
        ctrl.opb_sel   = idiv_pkg::OPB_SEL_KEEP_C;
        ctrl.opb_ld    = 1'b1;
        step_nxt       = idiv_pkg::STEP_NEG_QUOT;
      end

      idiv_pkg::STEP_NEG_QUOT: begin
        // C <= ~B + 1
        // a zero divisor keeps its all-ones quotient unsigned
        ctrl.opa_clr   = 1'b1;
        ctrl.opb_inv   = 1'b1;
        ctrl.adder_cin = 1'b1;
        ctrl.opc_sel   = idiv_pkg::OPC_SEL_SUM;
        ctrl.opc_ld    = q_neg_r & ~ctrl.divisor_zero;
        step_nxt       = idiv_pkg::STEP_DONE;
      end

      idiv_pkg::STEP_DONE: begin
        // results held until the consumer takes them
        if (yumi_i) begin
          step_nxt = idiv_pkg::STEP_IDLE;
        end
      end

      default: begin
        step_nxt = idiv_pkg::STEP_IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/idiv_iterative.sv
// iterative integer divider, 32-bit signed or unsigned
// valid/ready request, valid/yumi result, quotient and remainder together
// step controller and datapath joined by one control bundle
`timescale 1ns/1ps
`default_nettype none

module idiv_iterative (
  input  logic                            clk_i,
  input  logic                            arst_n_i,

  // request
  input  logic                            v_i,
  output logic                            ready_o,
  input  logic [idiv_pkg::DATA_WIDTH-1:0] dividend_i,
  input  logic [idiv_pkg::DATA_WIDTH-1:0] divisor_i,
  input  logic                            signed_div_i,

  // result
  output logic                            v_o,
  output logic [idiv_pkg::DATA_WIDTH-1:0] quotient_o,
  output logic [idiv_pkg::DATA_WIDTH-1:0] remainder_o,
  input  logic                            yumi_i
);

  // ----------------------------------------
  // control bundle
  // ----------------------------------------
  idiv_ctrl_if ctrl_if ();

  // sequencing and handshake
  idiv_controller u_idiv_controller (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .v_i      (v_i),
    .ready_o  (ready_o),
    .v_o      (v_o),
    .yumi_i   (yumi_i),
    .ctrl     (ctrl_if.ctrl)
  );

  // operand storage and the adder
  idiv_datapath u_idiv_datapath (
    .clk_i        (clk_i),
    .dividend_i   (dividend_i),
    .divisor_i    (divisor_i),
    .signed_div_i (signed_div_i),
    .quotient_o   (quotient_o),
    .remainder_o  (remainder_o),
    .ctrl         (ctrl_if.dp)
  );

endmodule

`default_nettype wire

//--- verif/idiv_ref_model.svh
// reference model of the iterative divider
// expected quotient and remainder for signed and unsigned requests,
// with the divide-by-zero and overflow rules of the RISC-V M extension
`ifndef IDIV_REF_MODEL_SVH
`define IDIV_REF_MODEL_SVH

// ----------------------------------------
// expected result of one division
// ----------------------------------------
function automatic void compute_expected(
  input  logic [idiv_pkg::DATA_WIDTH-1:0] dividend,
  input  logic [idiv_pkg::DATA_WIDTH-1:0] divisor,
  input  logic                            is_signed,
  output logic [idiv_pkg::DATA_WIDTH-1:0] quot,
  output logic [idiv_pkg::DATA_WIDTH-1:0] rem
);
  logic signed [idiv_pkg::DATA_WIDTH-1:0] sa;
  logic signed [idiv_pkg::DATA_WIDTH-1:0] sb;
  logic        [idiv_pkg::DATA_WIDTH-1:0] min_int;
  sa      = dividend;
  sb      = divisor;
  min_int = {1'b1, {(idiv_pkg::DATA_WIDTH-1){1'b0}}};
  if (divisor == '0) begin
    // zero divisor, all-ones quotient, dividend comes back as remainder
    quot = '1;
    rem  = dividend;
  end else if (is_signed && dividend == min_int && divisor == '1) begin
    // signed overflow wraps back to the most negative number
    quot = min_int;
    rem  = '0;
  end else if (is_signed) begin
    // truncation toward zero, remainder follows the dividend sign
    quot = sa / sb;
    rem  = sa % sb;
  end else begin
    quot = dividend / divisor;
    rem  = dividend % divisor;
  end
endfunction

`endif

//--- verif/tb_idiv_iterative.sv
// testbench of the iterative divider
// random signed and unsigned divisions with random result stalls,
// checked against the reference model, plus corner cases and latency
`timescale 1ns/1ps
`default_nettype none

module tb_idiv_iterative;

  localparam int W              = idiv_pkg::DATA_WIDTH;
  localparam int READY_TIMEOUT  = 100;
  localparam int RESULT_TIMEOUT = idiv_pkg::DIV_LATENCY + 20;

  logic         clk_i;
  logic         arst_n_i;
  logic         v_i;
  logic         ready_o;
  logic [W-1:0] dividend_i;
  logic [W-1:0] divisor_i;
  logic         signed_div_i;
  logic         v_o;
  logic [W-1:0] quotient_o;
  logic [W-1:0] remainder_o;
  logic         yumi_i;

  integer seed;
  int     error_count;
  int     check_count;
  bit     timed_out;

  `include "idiv_ref_model.svh"

  idiv_iterative u_idiv_iterative (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .v_i          (v_i),
    .ready_o      (ready_o),
    .dividend_i   (dividend_i),
    .divisor_i    (divisor_i),
    .signed_div_i (signed_div_i),
    .v_o          (v_o),
    .quotient_o   (quotient_o),
    .remainder_o  (remainder_o),
    .yumi_i       (yumi_i)
  );

  // 40 ns clock
  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // ----------------------------------------
  // checking helpers
  // ----------------------------------------
  task automatic compare_word(input string name, input logic [W-1:0] got,
                              input logic [W-1:0] exp);
    check_count++;
    assert (got === exp) else begin
      error_count++;
      $display("error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic require(input bit cond, input string what);
    check_count++;
    assert (cond) else begin
      error_count++;
      $display("%s", what);
    end
  endtask

  task automatic flag_timeout(input string what);
    timed_out = 1'b1;
    error_count++;
    $display("timeout: %s", what);
  endtask

  // operand with a random magnitude, sign kept for signed requests
  function automatic logic [W-1:0] random_operand(input bit keep_sign);
    logic [W-1:0] raw;
    int           shift;
    raw   = $random(seed);
    shift = int'($unsigned($random(seed)) % W);
    if (keep_sign) begin
      return W'($signed(raw) >>> shift);
    end
    return raw >> shift;
  endfunction

  // ----------------------------------------
  // one request, its result and its stall
  // ----------------------------------------
  // outputs are read right after a rising edge, so they show the
  // value of the cycle that this edge closes
  task automatic run_division(input logic [W-1:0] a, input logic [W-1:0] b,
                              input logic s, input int yumi_delay);
    logic [W-1:0] exp_q;
    logic [W-1:0] exp_r;
    logic [W-1:0] got_q;
    logic [W-1:0] got_r;
    int           waited;
    int           edges;
    if (timed_out) return;
    compute_expected(a, b, s, exp_q, exp_r);
    v_i          <= 1'b1;
    dividend_i   <= a;
    divisor_i    <= b;
    signed_div_i <= s;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (!ready_o && waited < READY_TIMEOUT);
    if (!ready_o) begin
      flag_timeout("ready_o never rose for a pending request");
      return;
    end
    // this edge accepted the request
    v_i <= 1'b0;
    edges = 0;
    do begin
      @(posedge clk_i);
      edges++;
    end while (!v_o && edges < RESULT_TIMEOUT);
    if (!v_o) begin
      flag_timeout("v_o never rose after an accepted request");
      return;
    end
    // v_o came up right after the previous edge
    require(edges - 1 == idiv_pkg::DIV_LATENCY,
            $sformatf("v_o rose %0d cycles after the accepting edge, not %0d",
                      edges - 1, idiv_pkg::DIV_LATENCY));
    got_q = quotient_o;
    got_r = remainder_o;
    compare_word("quotient_o", got_q, exp_q);
    compare_word("remainder_o", got_r, exp_r);
    // consumer stalls, the result must hold
    repeat (yumi_delay) begin
      @(posedge clk_i);
      require(v_o, "v_o dropped while the consumer stalled");
      require(!ready_o, "ready_o rose while the result was still pending");
      compare_word("quotient_o", quotient_o, got_q);
      compare_word("remainder_o", remainder_o, got_r);
    end
    yumi_i <= 1'b1;
    @(posedge clk_i);
    require(v_o, "v_o was low on the yumi edge");
    yumi_i <= 1'b0;
    @(posedge clk_i);
    require(ready_o, "ready_o did not return on the cycle after the yumi edge");
    require(!v_o, "v_o stayed high after the yumi edge");
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin
    logic [W-1:0] a;
    logic [W-1:0] b;
    int           delay;
    seed         = 32'hcc55_cc14;
    error_count  = 0;
    check_count  = 0;
    timed_out    = 1'b0;
    arst_n_i     <= 1'b0;
    v_i          <= 1'b0;
    yumi_i       <= 1'b0;
    dividend_i   <= '0;
    divisor_i    <= '0;
    signed_div_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    require(ready_o, "ready_o is low after reset");
    require(!v_o, "v_o is high after reset");

    // unsigned random pairs
    for (int i = 0; i < 300 && !timed_out; i++) begin
      a     = random_operand(1'b0);
      b     = random_operand(1'b0);
      delay = int'($unsigned($random(seed)) % 4);
      run_division(a, b, 1'b0, delay);
    end
    // signed pairs, every sign combination
    for (int i = 0; i < 200 && !timed_out; i++) begin
      a     = random_operand(1'b1);
      b     = random_operand(1'b1);
      delay = int'($unsigned($random(seed)) % 4);
      run_division(a, b, 1'b1, delay);
    end

    // zero divisor and signed overflow
    run_division(32'h1234_5678, 32'h0000_0000, 1'b0, 1);
    run_division(32'hffff_fff0, 32'h0000_0000, 1'b1, 0);
    run_division(32'h0000_0007, 32'h0000_0000, 1'b1, 2);
    run_division(32'h8000_0000, 32'hffff_ffff, 1'b1, 0);
    run_division(32'h8000_0000, 32'hffff_ffff, 1'b0, 0);
    run_division(32'h8000_0000, 32'h0000_0001, 1'b1, 0);
    // long stall on the result
    run_division(32'd1000, 32'd7, 1'b0, 12);

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+verif
hw/idiv_pkg.sv
hw/idiv_ctrl_if.sv
hw/idiv_datapath.sv
hw/idiv_controller.sv
hw/idiv_iterative.sv
verif/tb_idiv_iterative.sv

//--- run_sim.sh
#!/bin/sh
# build and run the divider testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module tb_idiv_iterative \
  -f flist.f \
  --Mdir obj_dir \
  -o sim_idiv

output=$(./obj_dir/sim_idiv)
echo "$output"

if echo "$output" | grep -q "TEST PASSED"; then
  exit 0
else
  exit 1
fi
